/* source/frontend_pkg.sv */
package frontend_pkg;

    // byte address width of the core
    localparam int ADDR_WIDTH = 32;

    // one instruction word
    localparam int INSTR_WIDTH = 32;

    // instructions per fetch block
    localparam int FETCH_WIDTH = 4;

    // pc step between sequential blocks
    localparam int FETCH_BYTES = 16;

    // icache line, bits and bytes
    localparam int LINE_WIDTH = 128;
    // line bases are aligned to this
    localparam int LINE_BYTES = 16;

    // fetch target queue size
    localparam int FTQ_DEPTH = 8;
    // pointer width, count is one bit wider
    localparam int FTQ_PTR_WIDTH = 3;

    // first fetch address out of reset
    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h1c000000;

    // fetch unit states
    typedef enum logic [1:0] {
        // waiting for a block from the queue
        FETCH_IDLE  = 2'b00,
        // cache lines outstanding
        FETCH_WAIT  = 2'b01,
        // group ready, held while stalled
        FETCH_OUT   = 2'b10,
        // swallowing late responses after a flush
        FETCH_DRAIN = 2'b11
    } fetch_state_e;

endpackage

/* source/fetch_target_queue.sv */
`timescale 1ns/1ps

module fetch_target_queue (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  flush_i,
    input  logic                                  push_valid_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0]   push_pc_i,
    output logic                                  full_o,
    output logic                                  fetch_valid_o,
    output logic [frontend_pkg::ADDR_WIDTH-1:0]   fetch_pc_o,
    input  logic                                  fetch_accept_i,
    input  logic                                  commit_i
);
    import frontend_pkg::*;

    // block start pcs
    logic [ADDR_WIDTH-1:0]    pc_mem [FTQ_DEPTH];
    // per entry: written, and handed to the fetch unit
    logic [FTQ_DEPTH-1:0]     valid_q;
    logic [FTQ_DEPTH-1:0]     fetched_q;
    logic [FTQ_PTR_WIDTH-1:0] wr_ptr_q;
    logic [FTQ_PTR_WIDTH-1:0] fetch_ptr_q;
    logic [FTQ_PTR_WIDTH-1:0] commit_ptr_q;
    // occupancy, entries stay counted until commit
    logic [FTQ_PTR_WIDTH:0]   count_q;
    logic                     push;
    logic                     fetch;
    logic                     commit;

    assign full_o = (count_q == (FTQ_PTR_WIDTH + 1)'(FTQ_DEPTH));

    // oldest entry written but not yet fetched
    assign fetch_valid_o = valid_q[fetch_ptr_q] && !fetched_q[fetch_ptr_q];
    assign fetch_pc_o    = pc_mem[fetch_ptr_q];

    // a push in the flush cycle belongs to the old stream
    assign push  = push_valid_i && !full_o && !flush_i;
    assign fetch = fetch_accept_i && fetch_valid_o;
    // commit only frees an entry that was already fetched
    assign commit = commit_i && valid_q[commit_ptr_q] && fetched_q[commit_ptr_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q     <= '0;
            fetch_ptr_q  <= '0;
            commit_ptr_q <= '0;
            count_q      <= '0;
            valid_q      <= '0;
            fetched_q    <= '0;
        end else if (flush_i) begin
            // redirect drops every block in flight
            wr_ptr_q     <= '0;
            fetch_ptr_q  <= '0;
            commit_ptr_q <= '0;
            count_q      <= '0;
            valid_q      <= '0;
            fetched_q    <= '0;
        end else begin
            if (push) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= wr_ptr_q + 1'b1;
            end
            if (fetch) begin
                fetched_q[fetch_ptr_q] <= 1'b1;
                fetch_ptr_q            <= fetch_ptr_q + 1'b1;
            end
            // push only hits the commit slot when the queue is empty
            if (commit) begin
                valid_q[commit_ptr_q]   <= 1'b0;
                fetched_q[commit_ptr_q] <= 1'b0;
                commit_ptr_q            <= commit_ptr_q + 1'b1;
            end
            case ({push, commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q] <= push_pc_i;
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic                                                        flush_i,
    input  logic                                                        ftq_valid_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0]                         ftq_pc_i,
    output logic                                                        ftq_accept_o,
    output logic [1:0]                                                  icache_rreq_o,
    output logic [1:0][frontend_pkg::ADDR_WIDTH-1:0]                    icache_raddr_o,
    input  logic [1:0]                                                  icache_rvalid_i,
    input  logic [1:0][frontend_pkg::LINE_WIDTH-1:0]                    icache_rdata_i,
    input  logic                                                        stall_i,
    output logic                                                        instr_valid_o,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::ADDR_WIDTH-1:0]  instr_pc_o,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::INSTR_WIDTH-1:0] instr_o
);
    import frontend_pkg::*;

    fetch_state_e               state_q;
    fetch_state_e               state_d;
    // block start pc of the group in flight
    logic [ADDR_WIDTH-1:0]      blk_pc_q;
    logic [ADDR_WIDTH-1:0]      line_base;
    logic [1:0][LINE_WIDTH-1:0] line_q;
    // request issued, response not yet seen
    logic [1:0]                 outst_q;
    // line captured for the current block
    logic [1:0]                 got_q;
    logic                       cross_line;
    logic [1:0]                 rsp;
    logic [1:0]                 outst_left;
    logic                       lines_done;
    logic [2*LINE_WIDTH-1:0]    line_pair;

    // block spills into the next line unless it starts at word 0
    assign cross_line = (blk_pc_q[3:2] != 2'b00);

    assign rsp        = outst_q & icache_rvalid_i;
    assign outst_left = outst_q & ~icache_rvalid_i;
    // all needed lines held or landing this cycle
    assign lines_done = (got_q[0] | rsp[0]) & (~cross_line | got_q[1] | rsp[1]);

    // take a new block only when idle and not being redirected
    assign ftq_accept_o = (state_q == FETCH_IDLE) && ftq_valid_i && !flush_i;

    // request level stays up until its response
    assign icache_rreq_o     = outst_q;
    assign line_base         = {blk_pc_q[ADDR_WIDTH-1:4], 4'b0000};
    assign icache_raddr_o[0] = line_base;
    assign icache_raddr_o[1] = line_base + ADDR_WIDTH'(LINE_BYTES);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            FETCH_IDLE: begin
                if (ftq_accept_o) begin
                    state_d = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (lines_done) begin
                    state_d = FETCH_OUT;
                end
            end
            FETCH_OUT: begin
                // shown once the buffer has room
                if (!stall_i) begin
                    state_d = FETCH_IDLE;
                end
            end
            FETCH_DRAIN: begin
                if (outst_left == 2'b00) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
        // flush wins, drain only if the cache still owes a response
        if (flush_i) begin
            state_d = (outst_left != 2'b00) ? FETCH_DRAIN : FETCH_IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= FETCH_IDLE;
            outst_q <= '0;
            got_q   <= '0;
        end else begin
            state_q <= state_d;
            if (ftq_accept_o) begin
                // port 1 only for a line-crossing block
                outst_q <= {(ftq_pc_i[3:2] != 2'b00), 1'b1};
                got_q   <= '0;
            end else begin
                outst_q <= outst_left;
                got_q   <= got_q | rsp;
            end
        end
    end

    // block pc and line data, no reset
    always_ff @(posedge clk) begin
        if (ftq_accept_o) begin
            blk_pc_q <= ftq_pc_i;
        end
        for (int p = 0; p < 2; p++) begin
            if (rsp[p]) begin
                line_q[p] <= icache_rdata_i[p];
            end
        end
    end

    // second line sits above the first
    assign line_pair = {line_q[1], line_q[0]};

    always_comb begin : extract
        logic [2:0] word_idx;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            // word offset in the line pair, at most 6
            word_idx      = {1'b0, blk_pc_q[3:2]} + 3'(k);
            instr_o[k]    = line_pair[word_idx*INSTR_WIDTH +: INSTR_WIDTH];
            instr_pc_o[k] = blk_pc_q + ADDR_WIDTH'(k * (INSTR_WIDTH / 8));
        end
    end

    // group is dropped if the flush lands in the output cycle
    assign instr_valid_o = (state_q == FETCH_OUT) && !stall_i && !flush_i;

endmodule

/* source/frontend.sv */
`timescale 1ns/1ps

module frontend (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0]                         backend_next_pc_i,
    input  logic                                                        backend_flush_i,
    input  logic                                                        backend_commit_i,
    input  logic                                                        instr_buffer_stall_i,
    output logic [1:0]                                                  icache_read_req_o,
    output logic [1:0][frontend_pkg::ADDR_WIDTH-1:0]                    icache_read_addr_o,
    input  logic [1:0]                                                  icache_read_valid_i,
    input  logic [1:0][frontend_pkg::LINE_WIDTH-1:0]                    icache_read_data_i,
    output logic                                                        instr_valid_o,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::ADDR_WIDTH-1:0]  instr_pc_o,
    output logic [frontend_pkg::FETCH_WIDTH-1:0][frontend_pkg::INSTR_WIDTH-1:0] instr_o
);
    import frontend_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_q;
    logic [ADDR_WIDTH-1:0] next_pc;
    logic                  bpu_valid;
    logic                  ftq_full;
    logic                  ftq_valid;
    logic [ADDR_WIDTH-1:0] ftq_pc;
    logic                  ifu_accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    // no predictor, next block is always sequential
    always_comb begin
        if (backend_flush_i) begin
            next_pc = backend_next_pc_i;
        end else if (ftq_full) begin
            // hold until a commit frees a slot
            next_pc = pc_q;
        end else begin
            next_pc = pc_q + ADDR_WIDTH'(FETCH_BYTES);
        end
    end

    // every pc becomes a block while there is room
    assign bpu_valid = !ftq_full;

    fetch_target_queue u_ftq (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (backend_flush_i),
        .push_valid_i   (bpu_valid),
        .push_pc_i      (pc_q),
        .full_o         (ftq_full),
        .fetch_valid_o  (ftq_valid),
        .fetch_pc_o     (ftq_pc),
        .fetch_accept_i (ifu_accept),
        .commit_i       (backend_commit_i)
    );

    fetch_unit u_ifu (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (backend_flush_i),
        .ftq_valid_i     (ftq_valid),
        .ftq_pc_i        (ftq_pc),
        .ftq_accept_o    (ifu_accept),
        .icache_rreq_o   (icache_read_req_o),
        .icache_raddr_o  (icache_read_addr_o),
        .icache_rvalid_i (icache_read_valid_i),
        .icache_rdata_i  (icache_read_data_i),
        .stall_i         (instr_buffer_stall_i),
        .instr_valid_o   (instr_valid_o),
        .instr_pc_o      (instr_pc_o),
        .instr_o         (instr_o)
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held over eight rising edges, released just after the last
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;
    end

endmodule

/* dv/icache_model.sv */
`timescale 1ns/1ps

module icache_model (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [1:0]                              req_i,
    input  logic [1:0][frontend_pkg::ADDR_WIDTH-1:0] addr_i,
    output logic [1:0]                              valid_o,
    output logic [1:0][frontend_pkg::LINE_WIDTH-1:0] data_o
);
    import frontend_pkg::*;

    integer                     seed = 32'h2747;
    logic [1:0]                 busy;
    int                         delay [2];
    logic [1:0][ADDR_WIDTH-1:0] line_addr;

    // every word holds its own byte address, scrambled
    function automatic logic [LINE_WIDTH-1:0] line_data(input logic [ADDR_WIDTH-1:0] base);
        logic [LINE_WIDTH-1:0] line;
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            line[w*INSTR_WIDTH +: INSTR_WIDTH] = (base + ADDR_WIDTH'(4 * w)) ^ 32'ha5a5_0000;
        end
        return line;
    endfunction

    initial begin
        valid_o = '0;
        data_o  = '0;
        busy    = '0;
    end

    // both ports in one process so the random sequence is fixed
    always begin
        @(posedge clk);
        #10;
        for (int p = 0; p < 2; p++) begin
            if (!rst_n) begin
                valid_o[p] = 1'b0;
                busy[p]    = 1'b0;
            end else if (valid_o[p]) begin
                // taken at this edge, one response per request
                valid_o[p] = 1'b0;
                busy[p]    = 1'b0;
            end else if (busy[p]) begin
                delay[p] = delay[p] - 1;
                if (delay[p] == 0) begin
                    valid_o[p] = 1'b1;
                    data_o[p]  = line_data(line_addr[p]);
                end
            end else if (req_i[p]) begin
                busy[p]      = 1'b1;
                line_addr[p] = addr_i[p];
                // latency 1 to 4 cycles
                delay[p]     = 1 + ($unsigned($random(seed)) % 4);
            end
        end
    end

endmodule

/* dv/frontend_asserts.sv */
`timescale 1ns/1ps

module frontend_asserts (
    input logic                                 clk,
    input logic                                 rst_n,
    input frontend_pkg::fetch_state_e           state_i,
    input logic [1:0]                           req_i,
    input logic [1:0]                           rvalid_i,
    input logic                                 instr_valid_i,
    input logic                                 stall_i,
    input logic                                 flush_i,
    input logic                                 accept_i,
    input logic                                 full_i,
    input logic [frontend_pkg::FTQ_PTR_WIDTH:0] count_i
);
    import frontend_pkg::*;

    // failed assertions so far, read by the testbench top
    int unsigned fail_count = 0;

    // request levels wait for their response
    req0_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_i[0] && !rvalid_i[0] |=> req_i[0])
        else begin
            $error("port 0 request dropped before its response");
            fail_count++;
        end
    req1_held: assert property (@(posedge clk) disable iff (!rst_n)
        req_i[1] && !rvalid_i[1] |=> req_i[1])
        else begin
            $error("port 1 request dropped before its response");
            fail_count++;
        end

    // nothing shown under stall, and a stalled group stays in FETCH_OUT
    no_valid_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_valid_i && stall_i)
        && !($past(state_i == FETCH_OUT && stall_i && !flush_i) && state_i != FETCH_OUT))
        else begin
            $error("group shown or lost while the instruction buffer stalls");
            fail_count++;
        end

    // new block only from idle with both ports quiet
    accept_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        accept_i |-> state_i == FETCH_IDLE && req_i == 2'b00)
        else begin
            $error("queue entry accepted outside the idle state");
            fail_count++;
        end

    // count never passes the depth, full exactly at the depth
    full_only_at_depth: assert property (@(posedge clk) disable iff (!rst_n)
        (count_i <= FTQ_DEPTH) && (full_i == (count_i == FTQ_DEPTH)))
        else begin
            $error("queue count and full flag disagree");
            fail_count++;
        end

endmodule

/* dv/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb;
    import frontend_pkg::*;

    localparam int WAIT_LIMIT   = 200;
    localparam int QUIET_CYCLES = 40;

    logic                                    clk;
    logic                                    rst_n;
    logic [ADDR_WIDTH-1:0]                   next_pc;
    logic                                    flush;
    logic                                    commit;
    logic                                    stall;
    logic [1:0]                              rd_req;
    logic [1:0][ADDR_WIDTH-1:0]              rd_addr;
    logic [1:0]                              rd_valid;
    logic [1:0][LINE_WIDTH-1:0]              rd_data;
    logic                                    grp_valid;
    logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]  grp_pc;
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] grp_instr;

    // delivered groups, oldest first
    logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]  pc_fifo [$];
    logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] instr_fifo [$];
    int                                      pending_commits;
    bit                                      auto_commit;
    bit                                      port1_seen;
    logic [ADDR_WIDTH-1:0]                   exp_pc;
    integer                                  seed = 32'h2747;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    icache_model u_icache (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (rd_req),
        .addr_i  (rd_addr),
        .valid_o (rd_valid),
        .data_o  (rd_data)
    );

    frontend u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .backend_next_pc_i    (next_pc),
        .backend_flush_i      (flush),
        .backend_commit_i     (commit),
        .instr_buffer_stall_i (stall),
        .icache_read_req_o    (rd_req),
        .icache_read_addr_o   (rd_addr),
        .icache_read_valid_i  (rd_valid),
        .icache_read_data_i   (rd_data),
        .instr_valid_o        (grp_valid),
        .instr_pc_o           (grp_pc),
        .instr_o              (grp_instr)
    );

    // fetch unit and queue checks bound into the top level
    bind frontend frontend_asserts u_asserts (
        .clk           (clk),
        .rst_n         (rst_n),
        .state_i       (u_ifu.state_q),
        .req_i         (icache_read_req_o),
        .rvalid_i      (icache_read_valid_i),
        .instr_valid_i (instr_valid_o),
        .stall_i       (instr_buffer_stall_i),
        .flush_i       (backend_flush_i),
        .accept_i      (ifu_accept),
        .full_i        (ftq_full),
        .count_i       (u_ftq.count_q)
    );

    // outputs sampled at the falling edge
    always @(negedge clk) begin
        if (rst_n && grp_valid) begin
            pc_fifo.push_back(grp_pc);
            instr_fifo.push_back(grp_instr);
            if (auto_commit) begin
                pending_commits++;
            end
        end
        if (rst_n && rd_req[1]) begin
            port1_seen = 1'b1;
        end
    end

    // bound checker failures
    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_count != 0) begin
            report_failure("a bound assertion on the fetch unit or queue failed");
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] got,
                              input logic [ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH t=%0t %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_instr(input string name, input logic [INSTR_WIDTH-1:0] got,
                               input logic [INSTR_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH t=%0t %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH t=%0t %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    // advance to the drive point 10 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    // one commit per delivered group or per manual request
    task automatic collect_commits();
        forever begin
            step_cycle();
            commit = (pending_commits > 0);
            if (pending_commits > 0) begin
                pending_commits--;
            end
        end
    endtask

    // one-cycle flush issued from a drive point
    task automatic redirect(input logic [ADDR_WIDTH-1:0] pc, input bit commits_on);
        next_pc         = pc;
        flush           = 1'b1;
        pending_commits = 0;
        auto_commit     = commits_on;
        pc_fifo.delete();
        instr_fifo.delete();
        step_cycle();
        flush  = 1'b0;
        exp_pc = pc;
    endtask

    task automatic wait_for_req(input int port);
        int waited;
        waited = 0;
        while (rd_req[port] !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                report_failure($sformatf("no request on cache port %0d before timeout", port));
            end
            step_cycle();
            waited++;
        end
    endtask

    task automatic expect_group();
        logic [FETCH_WIDTH-1:0][ADDR_WIDTH-1:0]  pcs;
        logic [FETCH_WIDTH-1:0][INSTR_WIDTH-1:0] words;
        logic [ADDR_WIDTH-1:0]                   addr;
        int                                      waited;
        waited = 0;
        while (pc_fifo.size() == 0) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("no instruction group arrived before timeout");
            end
            step_cycle();
            waited++;
        end
        pcs   = pc_fifo.pop_front();
        words = instr_fifo.pop_front();
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            addr = exp_pc + ADDR_WIDTH'(4 * i);
            check_addr($sformatf("instr_pc_o[%0d]", i), pcs[i], addr);
            // each memory word is its own address xor a5a5_0000
            check_instr($sformatf("instr_o[%0d]", i), words[i], addr ^ 32'ha5a5_0000);
        end
        exp_pc = exp_pc + ADDR_WIDTH'(FETCH_BYTES);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            step_cycle();
        end
        if (pc_fifo.size() != 0) begin
            report_failure("a group was delivered although the queue was full");
        end
    endtask

    task automatic test_reset();
        int waited;
        waited = 0;
        // loop also covers the first cycle after release
        while (rst_n !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("reset was never released");
            end
            @(negedge clk);
            check_bit("icache_read_req_o[0]", rd_req[0], 1'b0);
            check_bit("icache_read_req_o[1]", rd_req[1], 1'b0);
            check_bit("instr_valid_o", grp_valid, 1'b0);
            check_bit("ftq_full", u_dut.ftq_full, 1'b0);
            check_bit("ifu_accept", u_dut.ifu_accept, 1'b0);
            waited++;
        end
        step_cycle();
        exp_pc = RESET_PC;
        expect_group();
    endtask

    task automatic test_sequential();
        port1_seen = 1'b0;
        repeat (20) begin
            expect_group();
        end
        check_bit("icache_read_req_o[1] seen", port1_seen, 1'b0);
    endtask

    task automatic test_cross_line();
        redirect(32'h1c000108, 1'b1);
        // both ports rise together on accept
        wait_for_req(1);
        check_bit("icache_read_req_o[0]", rd_req[0], 1'b1);
        check_addr("icache_read_addr_o[0]", rd_addr[0], 32'h1c000100);
        check_addr("icache_read_addr_o[1]", rd_addr[1], 32'h1c000110);
        expect_group();
        expect_group();
    endtask

    task automatic test_ftq_full();
        redirect(32'h1c002000, 1'b0);
        repeat (FTQ_DEPTH) begin
            expect_group();
        end
        expect_quiet(QUIET_CYCLES);
        // single commit frees one slot
        pending_commits = 1;
        expect_group();
        expect_quiet(QUIET_CYCLES);
    endtask

    task automatic test_stall();
        int hold;
        redirect(32'h1c003000, 1'b1);
        expect_group();
        expect_group();
        hold  = 4 + ($unsigned($random(seed)) % 12);
        stall = 1'b1;
        repeat (hold) begin
            @(negedge clk);
            check_bit("instr_valid_o", grp_valid, 1'b0);
        end
        step_cycle();
        stall = 1'b0;
        repeat (3) begin
            expect_group();
        end
    endtask

    task automatic test_flush_midflight();
        wait_for_req(0);
        // request still outstanding in this cycle
        redirect(32'h1c008000, 1'b1);
        repeat (3) begin
            expect_group();
        end
    endtask

    initial begin
        next_pc         = '0;
        flush           = 1'b0;
        commit          = 1'b0;
        stall           = 1'b0;
        pending_commits = 0;
        auto_commit     = 1'b1;
        port1_seen      = 1'b0;
        exp_pc          = RESET_PC;
        fork
            collect_commits();
        join_none
        test_reset();
        test_sequential();
        test_cross_line();
        test_ftq_full();
        test_stall();
        test_flush_midflight();
        if (u_dut.u_asserts.fail_count != 0) begin
            report_failure("a bound assertion on the fetch unit or queue failed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* sources.f */
source/frontend_pkg.sv
source/fetch_target_queue.sv
source/fetch_unit.sv
source/frontend.sv
dv/tb_clock_gen.sv
dv/icache_model.sv
dv/frontend_asserts.sv
dv/frontend_tb.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - files:
      - source/frontend_pkg.sv
      - source/fetch_target_queue.sv
      - source/fetch_unit.sv
      - source/frontend.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/icache_model.sv
      - dv/frontend_asserts.sv
      - dv/frontend_tb.sv
